/* vertex_pkg.sv */
// Widths, sizes and types shared by the vertex job front end.
// Modules refer to every item here by scoped name.

package vertex_pkg;

	//////////////////////////////////////////////////
	// Sizes
	//////////////////////////////////////////////////

	localparam int VERTEX_BITS    = 32;
	localparam int LINE_VERTICES  = 4;
	localparam int LINE_BITS      = VERTEX_BITS * LINE_VERTICES;
	localparam int LINE_BYTES     = LINE_BITS / 8;
	localparam int ADDR_BITS      = 32;
	localparam int JOB_DEPTH      = 8;
	localparam int JOB_PTR_BITS   = $clog2(JOB_DEPTH);
	localparam int JOB_COUNT_BITS = $clog2(JOB_DEPTH + 1);

	//////////////////////////////////////////////////
	// Vectors
	//////////////////////////////////////////////////

	typedef logic [VERTEX_BITS-1:0] vertex_word_t;
	// Also used as vertex count and filtered count
	typedef logic [VERTEX_BITS-1:0] vertex_id_t;
	typedef logic [ADDR_BITS-1:0] addr_t;
	typedef logic [LINE_BITS-1:0] line_t;
	// Valid vertices in a line, 1 to 4
	typedef logic [$clog2(LINE_VERTICES+1)-1:0] line_count_t;
	typedef logic [$clog2(LINE_VERTICES)-1:0] word_idx_t;
	typedef logic [JOB_PTR_BITS-1:0] job_ptr_t;
	typedef logic [JOB_COUNT_BITS-1:0] job_count_t;

	//////////////////////////////////////////////////
	// Enums
	//////////////////////////////////////////////////

	typedef enum logic [1:0] {
		IN_DEGREE  = 2'd0,
		OUT_DEGREE = 2'd1,
		EDGES_IDX  = 2'd2
	} vertex_array_e;

	typedef enum logic [2:0] {
		FETCH_IDLE,
		FETCH_SIZE,
		FETCH_IN,
		FETCH_OUT,
		FETCH_EDGES,
		FETCH_WAIT
	} fetch_state_e;

	typedef enum logic {
		ASM_COLLECT,
		ASM_EMIT
	} assemble_state_e;

endpackage

/* vertex_stream_if.sv */
// Vertex record stream from the line assembler to the job queue.
// A record moves on a clock edge with valid and ready both high.

`timescale 1ns/1ps

interface vertex_stream_if;

	logic                     valid;
	logic                     ready;
	vertex_pkg::vertex_id_t   id;
	vertex_pkg::vertex_word_t in_degree;
	vertex_pkg::vertex_word_t out_degree;
	vertex_pkg::vertex_word_t edges_idx;

	// Assembler side
	modport producer (
		output valid, id, in_degree, out_degree, edges_idx,
		input  ready
	);

	// Queue side
	modport consumer (
		input  valid, id, in_degree, out_degree, edges_idx,
		output ready
	);

endinterface

/* vertex_fetch_ctrl.sv */
// Job start and read command generation for the vertex front end.
// Walks the three arrays one line at a time and waits for each
// line to be consumed before sizing the next one.

`timescale 1ns/1ps

module vertex_fetch_ctrl (
	input  logic                      clock,
	input  logic                      rstn,
	input  logic                      start,
	input  vertex_pkg::vertex_id_t    num_vertices,
	input  vertex_pkg::addr_t         in_degree_base,
	input  vertex_pkg::addr_t         out_degree_base,
	input  vertex_pkg::addr_t         edges_idx_base,
	input  logic                      cmd_ready,
	input  logic                      line_done,
	output logic                      busy,
	output logic                      cmd_valid,
	output vertex_pkg::addr_t         cmd_addr,
	output vertex_pkg::vertex_array_e cmd_array,
	output vertex_pkg::line_count_t   cmd_count,
	output logic                      line_start,
	output vertex_pkg::line_count_t   line_count
);

	vertex_pkg::fetch_state_e state;
	vertex_pkg::addr_t        in_base;
	vertex_pkg::addr_t        out_base;
	vertex_pkg::addr_t        edges_base;
	vertex_pkg::addr_t        line_offset;
	vertex_pkg::vertex_id_t   remaining;
	vertex_pkg::line_count_t  line_size;

	assign busy       = (state != vertex_pkg::FETCH_IDLE);
	assign cmd_count  = line_size;
	assign line_count = line_size;

	//////////////////////////////////////////////////
	// Command mux
	//////////////////////////////////////////////////

	always_comb begin
		cmd_valid = 1'b0;
		cmd_array = vertex_pkg::IN_DEGREE;
		cmd_addr  = in_base + line_offset;
		case (state)
			vertex_pkg::FETCH_IN: begin
				cmd_valid = 1'b1;
			end
			vertex_pkg::FETCH_OUT: begin
				cmd_valid = 1'b1;
				cmd_array = vertex_pkg::OUT_DEGREE;
				cmd_addr  = out_base + line_offset;
			end
			vertex_pkg::FETCH_EDGES: begin
				cmd_valid = 1'b1;
				cmd_array = vertex_pkg::EDGES_IDX;
				cmd_addr  = edges_base + line_offset;
			end
			default: begin
			end
		endcase
	end

	//////////////////////////////////////////////////
	// Fetch FSM
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state       <= vertex_pkg::FETCH_IDLE;
			remaining   <= '0;
			line_offset <= '0;
			line_size   <= '0;
			line_start  <= 1'b0;
		end else begin
			line_start <= 1'b0;
			case (state)
				vertex_pkg::FETCH_IDLE: begin
					if (start) begin
						remaining   <= num_vertices;
						line_offset <= '0;
						state       <= vertex_pkg::FETCH_SIZE;
					end
				end
				vertex_pkg::FETCH_SIZE: begin
					if (remaining == '0) begin
						// Empty job ends here
						state <= vertex_pkg::FETCH_IDLE;
					end else if (remaining >= vertex_pkg::LINE_VERTICES) begin
						line_size <= vertex_pkg::line_count_t'(vertex_pkg::LINE_VERTICES);
						remaining <= remaining - vertex_pkg::vertex_id_t'(vertex_pkg::LINE_VERTICES);
						state     <= vertex_pkg::FETCH_IN;
					end else begin
						// Short last line
						line_size <= vertex_pkg::line_count_t'(remaining);
						remaining <= '0;
						state     <= vertex_pkg::FETCH_IN;
					end
				end
				vertex_pkg::FETCH_IN: begin
					if (cmd_ready) begin
						state <= vertex_pkg::FETCH_OUT;
					end
				end
				vertex_pkg::FETCH_OUT: begin
					if (cmd_ready) begin
						state <= vertex_pkg::FETCH_EDGES;
					end
				end
				vertex_pkg::FETCH_EDGES: begin
					if (cmd_ready) begin
						line_offset <= line_offset + vertex_pkg::addr_t'(vertex_pkg::LINE_BYTES);
						line_start  <= 1'b1;
						state       <= vertex_pkg::FETCH_WAIT;
					end
				end
				vertex_pkg::FETCH_WAIT: begin
					if (line_done) begin
						if (remaining == '0) begin
							state <= vertex_pkg::FETCH_IDLE;
						end else begin
							state <= vertex_pkg::FETCH_SIZE;
						end
					end
				end
				default: begin
					state <= vertex_pkg::FETCH_IDLE;
				end
			endcase
		end
	end

	// Array bases sampled with the accepted start
	always_ff @(posedge clock) begin
		if (state == vertex_pkg::FETCH_IDLE && start) begin
			in_base    <= in_degree_base;
			out_base   <= out_degree_base;
			edges_base <= edges_idx_base;
		end
	end

endmodule

/* vertex_line_assembler.sv */
// Collects the three response lines of one cache line and turns them
// into vertex records, one vertex per cycle. Vertices with a zero
// out-degree are dropped and counted; the rest go to the stream.

`timescale 1ns/1ps

module vertex_line_assembler (
	input  logic                      clock,
	input  logic                      rstn,
	input  logic                      start,
	input  logic                      line_start,
	input  vertex_pkg::line_count_t   line_count,
	input  logic                      rsp_valid,
	input  vertex_pkg::vertex_array_e rsp_array,
	input  vertex_pkg::line_t         rsp_data,
	output logic                      line_done,
	output vertex_pkg::vertex_id_t    filtered_count,
	vertex_stream_if.producer         out_stream
);

	vertex_pkg::assemble_state_e state;
	vertex_pkg::line_t           line_buf [0:2];
	logic [2:0]                  line_have;
	logic                        count_have;
	vertex_pkg::line_count_t     line_len;
	vertex_pkg::word_idx_t       word_idx;
	vertex_pkg::vertex_id_t      next_id;
	vertex_pkg::vertex_word_t    in_word;
	vertex_pkg::vertex_word_t    out_word;
	vertex_pkg::vertex_word_t    edge_word;
	logic                        line_ready;
	logic                        filter_now;
	logic                        push_now;
	logic                        advance;
	logic                        last_word;

	//////////////////////////////////////////////////
	// Word select with word 0 in the low bits
	//////////////////////////////////////////////////

	assign in_word   = line_buf[vertex_pkg::IN_DEGREE][word_idx*vertex_pkg::VERTEX_BITS +:
		vertex_pkg::VERTEX_BITS];
	assign out_word  = line_buf[vertex_pkg::OUT_DEGREE][word_idx*vertex_pkg::VERTEX_BITS +:
		vertex_pkg::VERTEX_BITS];
	assign edge_word = line_buf[vertex_pkg::EDGES_IDX][word_idx*vertex_pkg::VERTEX_BITS +:
		vertex_pkg::VERTEX_BITS];

	assign line_ready = (&line_have) && count_have;
	assign filter_now = (state == vertex_pkg::ASM_EMIT) && (out_word == '0);
	assign push_now   = out_stream.valid && out_stream.ready;
	assign advance    = filter_now || push_now;
	assign last_word  = (vertex_pkg::line_count_t'(word_idx) + 3'd1) == line_len;

	// Record held steady until the queue takes it
	assign out_stream.valid      = (state == vertex_pkg::ASM_EMIT) && (out_word != '0);
	assign out_stream.id         = next_id;
	assign out_stream.in_degree  = in_word;
	assign out_stream.out_degree = out_word;
	assign out_stream.edges_idx  = edge_word;

	//////////////////////////////////////////////////
	// Line capture
	//////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (rsp_valid) begin
			line_buf[rsp_array] <= rsp_data;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state          <= vertex_pkg::ASM_COLLECT;
			line_have      <= '0;
			count_have     <= 1'b0;
			line_len       <= '0;
			word_idx       <= '0;
			line_done      <= 1'b0;
			next_id        <= '0;
			filtered_count <= '0;
		end else begin
			line_done <= 1'b0;
			case (state)
				vertex_pkg::ASM_COLLECT: begin
					if (line_ready) begin
						state <= vertex_pkg::ASM_EMIT;
					end
				end
				vertex_pkg::ASM_EMIT: begin
					if (advance) begin
						next_id <= next_id + vertex_pkg::vertex_id_t'(1);
						if (last_word) begin
							// Line consumed and released to fetch
							state      <= vertex_pkg::ASM_COLLECT;
							word_idx   <= '0;
							line_have  <= '0;
							count_have <= 1'b0;
							line_done  <= 1'b1;
						end else begin
							word_idx <= word_idx + 1'b1;
						end
					end
				end
				default: begin
					state <= vertex_pkg::ASM_COLLECT;
				end
			endcase
			if (filter_now) begin
				filtered_count <= filtered_count + vertex_pkg::vertex_id_t'(1);
			end
			if (rsp_valid) begin
				line_have[rsp_array] <= 1'b1;
			end
			if (line_start) begin
				count_have <= 1'b1;
				line_len   <= line_count;
			end
			// New job restarts ids and the filter count
			if (start) begin
				next_id        <= '0;
				filtered_count <= '0;
			end
		end
	end

endmodule

/* vertex_job_queue.sv */
// Circular buffer of vertex jobs between the assembler and the consumer.
// Accepts records while not full and presents the oldest one.

`timescale 1ns/1ps

module vertex_job_queue (
	input  logic                     clock,
	input  logic                     rstn,
	input  logic                     job_ready,
	vertex_stream_if.consumer        in_stream,
	output logic                     job_valid,
	output vertex_pkg::vertex_id_t   job_id,
	output vertex_pkg::vertex_word_t job_in_degree,
	output vertex_pkg::vertex_word_t job_out_degree,
	output vertex_pkg::vertex_word_t job_edges_idx
);

	vertex_pkg::vertex_id_t   id_mem   [vertex_pkg::JOB_DEPTH];
	vertex_pkg::vertex_word_t in_mem   [vertex_pkg::JOB_DEPTH];
	vertex_pkg::vertex_word_t out_mem  [vertex_pkg::JOB_DEPTH];
	vertex_pkg::vertex_word_t edge_mem [vertex_pkg::JOB_DEPTH];
	vertex_pkg::job_ptr_t     wr_ptr;
	vertex_pkg::job_ptr_t     rd_ptr;
	vertex_pkg::job_count_t   count;
	logic                     push;
	logic                     pop;

	assign in_stream.ready = (count != vertex_pkg::job_count_t'(vertex_pkg::JOB_DEPTH));
	assign push            = in_stream.valid && in_stream.ready;
	assign job_valid       = (count != '0);
	assign pop             = job_valid && job_ready;

	// Oldest entry
	assign job_id         = id_mem[rd_ptr];
	assign job_in_degree  = in_mem[rd_ptr];
	assign job_out_degree = out_mem[rd_ptr];
	assign job_edges_idx  = edge_mem[rd_ptr];

	always_ff @(posedge clock) begin
		if (push) begin
			id_mem[wr_ptr]   <= in_stream.id;
			in_mem[wr_ptr]   <= in_stream.in_degree;
			out_mem[wr_ptr]  <= in_stream.out_degree;
			edge_mem[wr_ptr] <= in_stream.edges_idx;
		end
	end

	//////////////////////////////////////////////////
	// Pointers and occupancy
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			if (push && !pop) begin
				count <= count + 1'b1;
			end else if (pop && !push) begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

/* vertex_job_control.sv */
// Top of the vertex job front end. Fetch control issues the read
// commands, the line assembler builds records from the responses,
// and the job queue hands them to the consumer.

`timescale 1ns/1ps

module vertex_job_control (
	input  logic                      clock,
	input  logic                      rstn,
	// Start side
	input  logic                      start,
	input  vertex_pkg::vertex_id_t    num_vertices,
	input  vertex_pkg::addr_t         in_degree_base,
	input  vertex_pkg::addr_t         out_degree_base,
	input  vertex_pkg::addr_t         edges_idx_base,
	output logic                      busy,
	// Read commands
	output logic                      cmd_valid,
	input  logic                      cmd_ready,
	output vertex_pkg::addr_t         cmd_addr,
	output vertex_pkg::vertex_array_e cmd_array,
	output vertex_pkg::line_count_t   cmd_count,
	// Read responses
	input  logic                      rsp_valid,
	input  vertex_pkg::vertex_array_e rsp_array,
	input  vertex_pkg::line_t         rsp_data,
	// Jobs
	output logic                      job_valid,
	input  logic                      job_ready,
	output vertex_pkg::vertex_id_t    job_id,
	output vertex_pkg::vertex_word_t  job_in_degree,
	output vertex_pkg::vertex_word_t  job_out_degree,
	output vertex_pkg::vertex_word_t  job_edges_idx,
	output vertex_pkg::vertex_id_t    filtered_count
);

	logic                    line_start;
	logic                    line_done;
	vertex_pkg::line_count_t line_count;

	vertex_stream_if stream0 ();

	vertex_fetch_ctrl fetch0 (
		.clock           (clock),
		.rstn            (rstn),
		.start           (start),
		.num_vertices    (num_vertices),
		.in_degree_base  (in_degree_base),
		.out_degree_base (out_degree_base),
		.edges_idx_base  (edges_idx_base),
		.cmd_ready       (cmd_ready),
		.line_done       (line_done),
		.busy            (busy),
		.cmd_valid       (cmd_valid),
		.cmd_addr        (cmd_addr),
		.cmd_array       (cmd_array),
		.cmd_count       (cmd_count),
		.line_start      (line_start),
		.line_count      (line_count)
	);

	vertex_line_assembler asm0 (
		.clock          (clock),
		.rstn           (rstn),
		.start          (start),
		.line_start     (line_start),
		.line_count     (line_count),
		.rsp_valid      (rsp_valid),
		.rsp_array      (rsp_array),
		.rsp_data       (rsp_data),
		.line_done      (line_done),
		.filtered_count (filtered_count),
		.out_stream     (stream0.producer)
	);

	vertex_job_queue queue0 (
		.clock          (clock),
		.rstn           (rstn),
		.job_ready      (job_ready),
		.in_stream      (stream0.consumer),
		.job_valid      (job_valid),
		.job_id         (job_id),
		.job_in_degree  (job_in_degree),
		.job_out_degree (job_out_degree),
		.job_edges_idx  (job_edges_idx)
	);

endmodule

/* tb_vertex_memory.sv */
// Read memory model for the vertex job front end testbench.
// Holds random degree and edge-index words, toggles cmd_ready at random
// and answers each accepted command in order after 1 to 6 cycles.

`timescale 1ns/1ps

module tb_vertex_memory #(
	parameter int ZERO_FIRST = 1024,
	parameter int ZERO_LAST  = 2047
) (
	input  logic                      clock,
	input  logic                      rstn,
	input  logic                      cmd_valid,
	input  vertex_pkg::addr_t         cmd_addr,
	input  vertex_pkg::vertex_array_e cmd_array,
	output logic                      cmd_ready,
	output logic                      rsp_valid,
	output vertex_pkg::vertex_array_e rsp_array,
	output vertex_pkg::line_t         rsp_data
);

	localparam int MEM_WORDS = 4096;

	vertex_pkg::vertex_word_t  words [0:MEM_WORDS-1];
	vertex_pkg::addr_t         pend_addr [$];
	vertex_pkg::vertex_array_e pend_array [$];
	int                        pend_due [$];
	int                        cycle;
	int                        last_due;
	bit                        filled;

	// Out-degree words get a zero about one time in three
	task automatic fill_words();
		for (int i = 0; i < MEM_WORDS; i++) begin
			if (i >= ZERO_FIRST && i <= ZERO_LAST) begin
				if (($urandom % 3) == 0) begin
					words[i] = '0;
				end else begin
					words[i] = ($urandom % 1000) + 1;
				end
			end else begin
				words[i] = $urandom;
			end
		end
	endtask

	// Word 0 of the line in the low 32 bits
	function automatic vertex_pkg::line_t read_line(input vertex_pkg::addr_t addr);
		vertex_pkg::line_t line;
		int                idx;
		idx = int'(addr[13:2]);
		for (int j = 0; j < vertex_pkg::LINE_VERTICES; j++) begin
			line[j*vertex_pkg::VERTEX_BITS +: vertex_pkg::VERTEX_BITS] = words[idx + j];
		end
		return line;
	endfunction

	initial begin
		cmd_ready = 1'b0;
		rsp_valid = 1'b0;
		rsp_array = vertex_pkg::IN_DEGREE;
		rsp_data  = '0;
	end

	//////////////////////////////////////////////////
	// Response side driven just after the edge
	//////////////////////////////////////////////////

	always @(posedge clock) begin
		#1;
		rsp_valid = 1'b0;
		if (!rstn) begin
			if (!filled) begin
				fill_words();
				filled = 1'b1;
			end
			cmd_ready = 1'b0;
			cycle     = 0;
			last_due  = 0;
		end else begin
			cycle = cycle + 1;
			if (pend_due.size() != 0 && pend_due[0] <= cycle) begin
				rsp_valid = 1'b1;
				rsp_array = pend_array.pop_front();
				rsp_data  = read_line(pend_addr.pop_front());
				void'(pend_due.pop_front());
			end
			cmd_ready = (($urandom % 4) != 0);
		end
	end

	// Command seen here completes on the next rising edge
	always @(negedge clock) begin
		int due;
		if (rstn && cmd_valid && cmd_ready) begin
			due = cycle + 1 + int'($urandom % 6);
			if (due <= last_due) begin
				due = last_due + 1;
			end
			last_due = due;
			pend_addr.push_back(cmd_addr);
			pend_array.push_back(cmd_array);
			pend_due.push_back(due);
		end
	end

endmodule

/* tb_vertex_job_control.sv */
// Testbench for the vertex job front end. Runs a series of jobs over
// random arrays, predicts commands, jobs and filtered counts from the
// memory contents, and checks them as they leave the DUT.

`timescale 1ns/1ps

module tb_vertex_job_control;

	localparam int                NUM_JOBS      = 12;
	localparam int                BUSY_TIMEOUT  = 3000;
	localparam int                DRAIN_TIMEOUT = 3000;
	localparam int                HOLD_CYCLES   = 200;
	localparam vertex_pkg::addr_t IN_REGION     = 32'h0000_0000;
	localparam vertex_pkg::addr_t OUT_REGION    = 32'h0000_1000;
	localparam vertex_pkg::addr_t EDGE_REGION   = 32'h0000_2000;

	logic                      clock;
	logic                      rstn;
	logic                      start;
	vertex_pkg::vertex_id_t    num_vertices;
	vertex_pkg::addr_t         in_degree_base;
	vertex_pkg::addr_t         out_degree_base;
	vertex_pkg::addr_t         edges_idx_base;
	logic                      busy;
	logic                      cmd_valid;
	logic                      cmd_ready;
	vertex_pkg::addr_t         cmd_addr;
	vertex_pkg::vertex_array_e cmd_array;
	vertex_pkg::line_count_t   cmd_count;
	logic                      rsp_valid;
	vertex_pkg::vertex_array_e rsp_array;
	vertex_pkg::line_t         rsp_data;
	logic                      job_valid;
	logic                      job_ready;
	vertex_pkg::vertex_id_t    job_id;
	vertex_pkg::vertex_word_t  job_in_degree;
	vertex_pkg::vertex_word_t  job_out_degree;
	vertex_pkg::vertex_word_t  job_edges_idx;
	vertex_pkg::vertex_id_t    filtered_count;

	// Expected traffic of the running job
	vertex_pkg::addr_t         exp_cmd_addr [$];
	vertex_pkg::vertex_array_e exp_cmd_array [$];
	vertex_pkg::line_count_t   exp_cmd_count [$];
	vertex_pkg::vertex_id_t    exp_job_id [$];
	vertex_pkg::vertex_word_t  exp_job_in [$];
	vertex_pkg::vertex_word_t  exp_job_out [$];
	vertex_pkg::vertex_word_t  exp_job_edge [$];
	vertex_pkg::vertex_id_t    exp_filtered;

	int  cmd_errors;
	int  job_errors;
	int  count_errors;
	int  other_errors;
	int  jobs_seen;
	bit  hold_jobs;
	bit  timed_out;

	vertex_job_control dut0 (.*);

	tb_vertex_memory #(
		.ZERO_FIRST (int'(OUT_REGION >> 2)),
		.ZERO_LAST  (int'(EDGE_REGION >> 2) - 1)
	) mem0 (
		.clock     (clock),
		.rstn      (rstn),
		.cmd_valid (cmd_valid),
		.cmd_addr  (cmd_addr),
		.cmd_array (cmd_array),
		.cmd_ready (cmd_ready),
		.rsp_valid (rsp_valid),
		.rsp_array (rsp_array),
		.rsp_data  (rsp_data)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	always @(posedge clock) begin
		#1;
		job_ready = !hold_jobs && (($urandom % 3) != 0);
	end

	//////////////////////////////////////////////////
	// Compare tasks and run end
	//////////////////////////////////////////////////

	task automatic check_cmd(input vertex_pkg::addr_t got_addr, input vertex_pkg::addr_t exp_addr,
		input vertex_pkg::vertex_array_e got_array, input vertex_pkg::vertex_array_e exp_array,
		input vertex_pkg::line_count_t got_count, input vertex_pkg::line_count_t exp_count);
		if (got_addr !== exp_addr || got_array !== exp_array || got_count !== exp_count) begin
			cmd_errors++;
			$display("CHECK FAILED at %0t: command %h/%0d/%0d, expected %h/%0d/%0d", $time,
				got_addr, got_array, got_count, exp_addr, exp_array, exp_count);
		end
	endtask

	task automatic check_job(input vertex_pkg::vertex_id_t got_id,
		input vertex_pkg::vertex_id_t exp_id,
		input vertex_pkg::vertex_word_t got_in, input vertex_pkg::vertex_word_t exp_in,
		input vertex_pkg::vertex_word_t got_out, input vertex_pkg::vertex_word_t exp_out,
		input vertex_pkg::vertex_word_t got_edge, input vertex_pkg::vertex_word_t exp_edge);
		if (got_id !== exp_id || got_in !== exp_in || got_out !== exp_out
			|| got_edge !== exp_edge) begin
			job_errors++;
			$display("CHECK FAILED at %0t: job %0d %h %h %h, expected %0d %h %h %h", $time,
				got_id, got_in, got_out, got_edge, exp_id, exp_in, exp_out, exp_edge);
		end
	endtask

	task automatic check_count(input vertex_pkg::vertex_id_t got,
		input vertex_pkg::vertex_id_t expected, input string what);
		if (got !== expected) begin
			count_errors++;
			$display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, what, got, expected);
		end
	endtask

	task automatic finish_run();
		$display("Errors: command %0d, job %0d, count %0d, other %0d",
			cmd_errors, job_errors, count_errors, other_errors);
		if (cmd_errors + job_errors + count_errors + other_errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	endtask

	//////////////////////////////////////////////////
	// Monitors sampled mid-cycle
	//////////////////////////////////////////////////

	always @(negedge clock) begin
		if (rstn && cmd_valid && cmd_ready) begin
			if (exp_cmd_addr.size() == 0) begin
				other_errors++;
				$display("Unexpected read command at %0t to address %h", $time, cmd_addr);
			end else begin
				check_cmd(cmd_addr, exp_cmd_addr.pop_front(), cmd_array,
					exp_cmd_array.pop_front(), cmd_count, exp_cmd_count.pop_front());
			end
		end
		if (rstn && job_valid && job_ready) begin
			jobs_seen++;
			if (exp_job_id.size() == 0) begin
				other_errors++;
				$display("Unexpected job at %0t with id %0d", $time, job_id);
			end else begin
				check_job(job_id, exp_job_id.pop_front(), job_in_degree, exp_job_in.pop_front(),
					job_out_degree, exp_job_out.pop_front(), job_edges_idx,
					exp_job_edge.pop_front());
			end
		end
	end

	//////////////////////////////////////////////////
	// Reference model and job sequencing
	//////////////////////////////////////////////////

	task automatic build_expected(input vertex_pkg::vertex_id_t num, input vertex_pkg::addr_t in_b,
		input vertex_pkg::addr_t out_b, input vertex_pkg::addr_t edge_b);
		int                       left;
		int                       size;
		vertex_pkg::addr_t        offset;
		vertex_pkg::vertex_word_t w_in;
		vertex_pkg::vertex_word_t w_out;
		vertex_pkg::vertex_word_t w_edge;
		exp_filtered = '0;
		for (int k = 0; k * vertex_pkg::LINE_VERTICES < int'(num); k++) begin
			left   = int'(num) - k * vertex_pkg::LINE_VERTICES;
			size   = (left < vertex_pkg::LINE_VERTICES) ? left : vertex_pkg::LINE_VERTICES;
			offset = vertex_pkg::addr_t'(k * vertex_pkg::LINE_BYTES);
			exp_cmd_addr.push_back(in_b + offset);
			exp_cmd_addr.push_back(out_b + offset);
			exp_cmd_addr.push_back(edge_b + offset);
			exp_cmd_array.push_back(vertex_pkg::IN_DEGREE);
			exp_cmd_array.push_back(vertex_pkg::OUT_DEGREE);
			exp_cmd_array.push_back(vertex_pkg::EDGES_IDX);
			for (int c = 0; c < 3; c++) begin
				exp_cmd_count.push_back(vertex_pkg::line_count_t'(size));
			end
		end
		for (int v = 0; v < int'(num); v++) begin
			w_in   = mem0.words[int'(in_b >> 2) + v];
			w_out  = mem0.words[int'(out_b >> 2) + v];
			w_edge = mem0.words[int'(edge_b >> 2) + v];
			if (w_out == '0) begin
				exp_filtered = exp_filtered + 1;
			end else begin
				exp_job_id.push_back(vertex_pkg::vertex_id_t'(v));
				exp_job_in.push_back(w_in);
				exp_job_out.push_back(w_out);
				exp_job_edge.push_back(w_edge);
			end
		end
	endtask

	task automatic wait_busy_low();
		int n;
		n = 0;
		while (busy && n < BUSY_TIMEOUT) begin
			@(posedge clock);
			#1;
			n++;
		end
		if (busy) begin
			other_errors++;
			timed_out = 1'b1;
			$display("Timeout at %0t: busy never fell", $time);
		end
	endtask

	task automatic wait_jobs_drained();
		int n;
		n = 0;
		while (exp_job_id.size() != 0 && n < DRAIN_TIMEOUT) begin
			@(posedge clock);
			#1;
			n++;
		end
		if (exp_job_id.size() != 0) begin
			other_errors++;
			timed_out = 1'b1;
			$display("Timeout at %0t: %0d jobs never arrived", $time, exp_job_id.size());
		end
	endtask

	task automatic run_job(input int count, input bit hold);
		vertex_pkg::addr_t in_b;
		vertex_pkg::addr_t out_b;
		vertex_pkg::addr_t edge_b;
		in_b   = IN_REGION + vertex_pkg::addr_t'(($urandom % 128) * 16);
		out_b  = OUT_REGION + vertex_pkg::addr_t'(($urandom % 128) * 16);
		edge_b = EDGE_REGION + vertex_pkg::addr_t'(($urandom % 128) * 16);
		build_expected(vertex_pkg::vertex_id_t'(count), in_b, out_b, edge_b);
		jobs_seen = 0;
		hold_jobs = hold;
		@(posedge clock);
		#1;
		start           = 1'b1;
		num_vertices    = vertex_pkg::vertex_id_t'(count);
		in_degree_base  = in_b;
		out_degree_base = out_b;
		edges_idx_base  = edge_b;
		@(posedge clock);
		#1;
		start = 1'b0;
		if (busy !== 1'b1) begin
			other_errors++;
			$display("CHECK FAILED at %0t: busy did not rise after start", $time);
		end
		check_count(filtered_count, '0, "filtered_count after start");
		if (hold) begin
			// Queue fills while the consumer stalls
			for (int n = 0; n < HOLD_CYCLES; n++) begin
				@(posedge clock);
			end
			#1;
			if (jobs_seen != 0 || job_valid !== 1'b1) begin
				other_errors++;
				$display("CHECK FAILED at %0t: queue not holding jobs while stalled", $time);
			end
			hold_jobs = 1'b0;
		end
		wait_busy_low();
		if (timed_out) begin
			return;
		end
		check_count(filtered_count, exp_filtered, "filtered_count at end of job");
		if (exp_cmd_addr.size() != 0) begin
			other_errors++;
			$display("Job of %0d vertices ended with %0d commands missing", count,
				exp_cmd_addr.size());
		end
		wait_jobs_drained();
	endtask

	initial begin
		int count;
		void'($urandom(88668));
		rstn            = 1'b0;
		start           = 1'b0;
		num_vertices    = '0;
		in_degree_base  = '0;
		out_degree_base = '0;
		edges_idx_base  = '0;
		job_ready       = 1'b0;
		hold_jobs       = 1'b0;
		timed_out       = 1'b0;
		repeat (5) @(posedge clock);
		#1;
		rstn = 1'b1;
		if (busy !== 1'b0 || cmd_valid !== 1'b0 || job_valid !== 1'b0) begin
			other_errors++;
			$display("CHECK FAILED at %0t: outputs not idle after reset", $time);
		end
		check_count(filtered_count, '0, "filtered_count after reset");
		for (int i = 0; i < NUM_JOBS; i++) begin
			case (i)
				0: count = 1;
				1: count = 4;
				2: count = 5;
				3: count = 13;
				4: count = 0;
				5: count = 32;
				default: count = int'($urandom % 41);
			endcase
			run_job(count, i == 5);
			if (timed_out) begin
				break;
			end
		end
		if (!timed_out) begin
			repeat (10) @(posedge clock);
			#1;
			if (job_valid !== 1'b0) begin
				other_errors++;
				$display("CHECK FAILED at %0t: job queue not empty at end", $time);
			end
		end
		finish_run();
	end

endmodule

/* build.f */
vertex_pkg.sv
vertex_stream_if.sv
vertex_fetch_ctrl.sv
vertex_line_assembler.sv
vertex_job_queue.sv
vertex_job_control.sv
tb_vertex_memory.sv
tb_vertex_job_control.sv

/* run_sim.sh */
#!/bin/bash
# Build the testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f build.f --top-module tb_vertex_job_control || exit 1
out="$(./obj_dir/Vtb_vertex_job_control)"
echo "$out"
echo "$out" | grep -q "All tests passed" && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
